// File: memPkg.sv
package memPkg;

    // byte address space of the shared RAM
    localparam int AddrWidth = 12;
    localparam int RamDepth = 1 << AddrWidth;

    // client ports sharing the RAM
    localparam int NumPorts = 3;

    typedef logic [AddrWidth-1:0] addrT;
    typedef logic [7:0] byteT;
    typedef logic [31:0] wordT;
    typedef logic [1:0] portIdT;

    typedef enum logic {
        OpLoad,
        OpStore
    } memOpT;

    // 1, 2 or 4 bytes
    typedef enum logic [1:0] {
        SizeByte,
        SizeHalf,
        SizeWord
    } accessSizeT;

    // request as the client presents it
    typedef struct packed {
        memOpT      op;
        accessSizeT size;
        addrT       addr;
        wordT       wdata;
    } memReqT;

    // load data, zero-extended; zero for stores
    typedef struct packed {
        wordT rdata;
    } memRspT;

    // byte sequencer states
    typedef enum logic [1:0] {
        SeqIdle,
        SeqAddr,
        SeqData,
        SeqDone
    } seqStateT;

endpackage

// File: byteRam.sv
`timescale 1ns/10ps

module byteRam (
    input  logic         clk,
    input  memPkg::addrT addr,
    input  logic         we,
    input  memPkg::byteT wdata,
    output memPkg::byteT rdata
);
    import memPkg::*;

    byteT mem [RamDepth];

    // read returns the old byte on a write cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// File: byteSequencer.sv
`timescale 1ns/10ps

module byteSequencer (
    input  logic           clk,
    input  logic           rst,
    input  logic           hold,
    input  logic           start,
    input  memPkg::memReqT startReq,
    input  memPkg::portIdT startPort,
    output logic           busy,
    output logic           done,
    output memPkg::portIdT donePort,
    output memPkg::memRspT doneRsp,
    output memPkg::addrT   ramAddr,
    output logic           ramWe,
    output memPkg::byteT   ramWdata,
    input  memPkg::byteT   ramRdata
);
    import memPkg::*;

    seqStateT   state;
    logic [1:0] count;
    logic [1:0] lastIdx;
    logic [1:0] startLast;
    logic [1:0] capLane;
    logic       capValid;
    memOpT      op;
    addrT       curAddr;
    wordT       wBuf;
    wordT       rdWord;
    portIdT     port;

    always_comb begin
        case (startReq.size)
            SizeHalf: startLast = 2'd1;
            SizeWord: startLast = 2'd3;
            default:  startLast = 2'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SeqIdle;
            count <= '0;
            capValid <= 1'b0;
        end else if (state == SeqIdle) begin
            // a start is always taken, hold only stretches the byte cycles
            if (start) begin
                state <= SeqAddr;
                count <= '0;
            end
        end else if (!hold) begin
            case (state)
                SeqAddr: begin
                    count <= count + 1'b1;
                    capValid <= (op == OpLoad);
                    if (count == lastIdx) begin
                        state <= (op == OpLoad) ? SeqData : SeqDone;
                    end
                end
                SeqData: begin
                    capValid <= 1'b0;
                    state <= SeqDone;
                end
                SeqDone: state <= SeqIdle;
                default: state <= SeqIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == SeqIdle) begin
            if (start) begin
                op <= startReq.op;
                lastIdx <= startLast;
                curAddr <= startReq.addr;
                wBuf <= startReq.wdata;
                rdWord <= '0;
                port <= startPort;
            end
        end else if (!hold) begin
            if (state == SeqAddr) begin
                curAddr <= curAddr + 1'b1;
                wBuf <= wBuf >> 8;
                capLane <= count;
            end
            // byte from the previous address lands in its lane
            if (capValid) begin
                rdWord[{capLane, 3'b000} +: 8] <= ramRdata;
            end
        end
    end

    assign busy = (state != SeqIdle);
    assign done = (state == SeqDone) && !hold;
    assign donePort = port;
    assign doneRsp.rdata = rdWord;

    // during hold keep re-reading the byte still waiting for capture,
    // so ramRdata is right again when hold drops
    assign ramAddr = curAddr - addrT'(hold && capValid);
    assign ramWe = (state == SeqAddr) && (op == OpStore) && !hold;
    assign ramWdata = wBuf[7:0];

    // arbiter must respect busy
    startWhenIdle: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

// File: portArbiter.sv
`timescale 1ns/10ps

module portArbiter (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [memPkg::NumPorts-1:0] pending,
    input  memPkg::memReqT               pendReq [memPkg::NumPorts],
    input  logic                         busy,
    output logic [memPkg::NumPorts-1:0] grant,
    output logic                         start,
    output memPkg::memReqT               startReq,
    output memPkg::portIdT               startPort
);
    import memPkg::*;

    portIdT              ptr;
    portIdT              pick;
    logic                found;
    logic                launch;
    logic [NumPorts-1:0] launched;
    logic [NumPorts-1:0] avail;

    // ports already handed to the sequencer stay out until they drop pending
    assign avail = pending & ~launched;

    always_comb begin
        int idx;
        found = 1'b0;
        pick = '0;
        for (int off = 0; off < NumPorts; off++) begin
            idx = int'(ptr) + off;
            if (idx >= NumPorts) begin
                idx = idx - NumPorts;
            end
            if (!found && avail[idx]) begin
                found = 1'b1;
                pick = portIdT'(idx);
            end
        end
    end

    // start itself is the lockout, busy only shows up a cycle later
    assign launch = found && !busy && !start;

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
            launched <= '0;
            grant <= '0;
            start <= 1'b0;
        end else begin
            grant <= '0;
            start <= launch;
            launched <= launched & pending;
            if (launch) begin
                grant[pick] <= 1'b1;
                launched[pick] <= 1'b1;
                ptr <= (int'(pick) == NumPorts - 1) ? portIdT'(0) : pick + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            startReq <= pendReq[pick];
            startPort <= pick;
        end
    end

    // a granted port keeps pending until its response
    grantOneHot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(grant) && ((grant & ~pending) == '0));

endmodule

// File: memPortFront.sv
`timescale 1ns/10ps

module memPortFront #(
    parameter int PortIndex = 0
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           req,
    input  memPkg::memReqT reqData,
    output logic           ack,
    output memPkg::memRspT rspData,
    output logic           pending,
    output memPkg::memReqT pendReq,
    input  logic           done,
    input  memPkg::portIdT donePort,
    input  memPkg::memRspT doneRsp
);
    import memPkg::*;

    typedef enum logic [1:0] {
        FrontIdle,
        FrontWait,
        FrontAck
    } frontStateT;

    frontStateT state;
    logic       hit;

    // done is broadcast, only our index counts
    assign hit = done && (donePort == portIdT'(PortIndex));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FrontIdle;
        end else begin
            case (state)
                FrontIdle: if (req) state <= FrontWait;
                FrontWait: if (hit) state <= FrontAck;
                // hold ack until the client lets go of req
                FrontAck:  if (!req) state <= FrontIdle;
                default:   state <= FrontIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FrontIdle && req) begin
            pendReq <= reqData;
        end
        if (state == FrontWait && hit) begin
            rspData <= doneRsp;
        end
    end

    assign pending = (state == FrontWait);
    assign ack = (state == FrontAck);

    // four-phase rule seen from the client side
    ackNeedsReq: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req));

endmodule

// File: memSubsystem.sv
`timescale 1ns/10ps

module memSubsystem (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         hold,
    input  logic [memPkg::NumPorts-1:0] req,
    input  memPkg::memReqT               reqData [memPkg::NumPorts],
    output logic [memPkg::NumPorts-1:0] ack,
    output memPkg::memRspT               rspData [memPkg::NumPorts]
);
    import memPkg::*;

    logic [NumPorts-1:0] pending;
    memReqT              pendReq [NumPorts];
    logic [NumPorts-1:0] grant;
    logic                start;
    memReqT              startReq;
    portIdT              startPort;
    logic                busy;
    logic                done;
    portIdT              donePort;
    memRspT              doneRsp;
    addrT                ramAddr;
    logic                ramWe;
    byteT                ramWdata;
    byteT                ramRdata;

    for (genvar i = 0; i < NumPorts; i++) begin : genFront
        memPortFront #(
            .PortIndex(i)
        ) front (
            .clk     (clk),
            .rst     (rst),
            .req     (req[i]),
            .reqData (reqData[i]),
            .ack     (ack[i]),
            .rspData (rspData[i]),
            .pending (pending[i]),
            .pendReq (pendReq[i]),
            .done    (done),
            .donePort(donePort),
            .doneRsp (doneRsp)
        );
    end

    portArbiter arb0 (
        .clk      (clk),
        .rst      (rst),
        .pending  (pending),
        .pendReq  (pendReq),
        .busy     (busy),
        .grant    (grant),
        .start    (start),
        .startReq (startReq),
        .startPort(startPort)
    );

    byteSequencer seq0 (
        .clk      (clk),
        .rst      (rst),
        .hold     (hold),
        .start    (start),
        .startReq (startReq),
        .startPort(startPort),
        .busy     (busy),
        .done     (done),
        .donePort (donePort),
        .doneRsp  (doneRsp),
        .ramAddr  (ramAddr),
        .ramWe    (ramWe),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

    byteRam ram0 (
        .clk  (clk),
        .addr (ramAddr),
        .we   (ramWe),
        .wdata(ramWdata),
        .rdata(ramRdata)
    );

endmodule

// File: tbMemSubsystem.sv
`timescale 1ns/10ps

module tbMemSubsystem;
    import memPkg::*;

    localparam int WaitLimit = 200;

    logic                clk;
    logic                rst;
    logic                hold;
    logic [NumPorts-1:0] req;
    memReqT              reqData [NumPorts];
    logic [NumPorts-1:0] ack;
    memRspT              rspData [NumPorts];

    // reference memory, updated by the testbench's own stores
    byteT   model [RamDepth];
    integer seed;
    int     errors;

    memSubsystem dut0 (
        .clk    (clk),
        .rst    (rst),
        .hold   (hold),
        .req    (req),
        .reqData(reqData),
        .ack    (ack),
        .rspData(rspData)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stopRun(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic checkAck(input string name, input logic [NumPorts-1:0] got,
                            input logic [NumPorts-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "ack mismatch");
        end
    endtask

    function automatic int sizeBytes(input accessSizeT size);
        case (size)
            SizeHalf: return 2;
            SizeWord: return 4;
            default:  return 1;
        endcase
    endfunction

    // little-endian, bytes above the size stay zero
    function automatic wordT expectLoad(input accessSizeT size, input addrT addr);
        wordT w;
        w = '0;
        for (int i = 0; i < sizeBytes(size); i++) begin
            w[8*i +: 8] = model[addrT'(addr + i)];
        end
        return w;
    endfunction

    task automatic updateModel(input accessSizeT size, input addrT addr, input wordT wdata);
        for (int i = 0; i < sizeBytes(size); i++) begin
            model[addrT'(addr + i)] = wdata[8*i +: 8];
        end
    endtask

    task automatic applyReset();
        rst = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic waitAck(input int port);
        int n;
        n = 0;
        while (!ack[port]) begin
            @(negedge clk);
            n++;
            if (n > WaitLimit) stopRun($sformatf("timeout waiting for ack on port %0d", port));
        end
    endtask

    // one four-phase cycle, req kept high for keep cycles after ack
    task automatic doAccess(input int port, input memOpT op, input accessSizeT size,
                            input addrT addr, input wordT wdata, input int keep,
                            output wordT rdata);
        logic [NumPorts-1:0] mine;
        mine = '0;
        mine[port] = 1'b1;
        reqData[port] = '{op, size, addr, wdata};
        req[port] = 1'b1;
        @(negedge clk);
        waitAck(port);
        rdata = rspData[port].rdata;
        repeat (keep) begin
            @(negedge clk);
            checkAck("ack while req held", ack & mine, mine);
            checkAck("pending while ack", dut0.pending & mine, '0);
        end
        req[port] = 1'b0;
        @(negedge clk);
        checkAck("ack after req drop", ack & mine, '0);
        if (op == OpStore) begin
            checkWord("store rspData", rdata, '0);
            updateModel(size, addr, wdata);
        end
    endtask

    task automatic testWordLoad();
        wordT r;
        doAccess(0, OpStore, SizeWord, 12'h100, 32'hA1B2C3D4, 0, r);
        doAccess(0, OpLoad, SizeWord, 12'h100, '0, 0, r);
        checkWord("word load", r, 32'hA1B2C3D4);
        doAccess(0, OpLoad, SizeByte, 12'h100, '0, 0, r);
        checkWord("byte load", r, 32'h000000D4);
        doAccess(0, OpLoad, SizeHalf, 12'h100, '0, 0, r);
        checkWord("half load", r, 32'h0000C3D4);
        doAccess(0, OpLoad, SizeByte, 12'h102, '0, 0, r);
        checkWord("byte load lane 2", r, 32'h000000B2);
    endtask

    task automatic testLanes();
        wordT r;
        doAccess(1, OpStore, SizeWord, 12'h200, 32'h11223344, 0, r);
        doAccess(1, OpStore, SizeByte, 12'h201, 32'h000000EE, 0, r);
        doAccess(2, OpStore, SizeHalf, 12'h202, 32'h0000BEEF, 0, r);
        doAccess(0, OpLoad, SizeWord, 12'h200, '0, 0, r);
        checkWord("merged word", r, 32'hBEEFEE44);
        checkWord("merged word model", r, expectLoad(SizeWord, 12'h200));
    endtask

    task automatic testRandom();
        int         p;
        addrT       a;
        wordT       w;
        wordT       r;
        accessSizeT sz;
        for (int k = 0; k < 24; k++) begin
            p = k % NumPorts;
            // some accesses start near the top so they wrap
            a = (k % 6 == 0) ? addrT'(RamDepth - 1 - (k % 4)) : addrT'($random(seed));
            w = $random(seed);
            doAccess(p, OpStore, SizeWord, a, w, 0, r);
            sz = accessSizeT'($unsigned($random(seed)) % 3);
            doAccess((p + 1) % NumPorts, OpLoad, sz, a, '0, 0, r);
            checkWord("random load", r, expectLoad(sz, a));
            sz = accessSizeT'($unsigned($random(seed)) % 3);
            w = $random(seed);
            doAccess(p, OpStore, sz, a, w, 0, r);
            doAccess((p + 2) % NumPorts, OpLoad, SizeWord, a, '0, 0, r);
            checkWord("random word load", r, expectLoad(SizeWord, a));
        end
    endtask

    task automatic testRoundRobin();
        wordT                r;
        int                  order;
        int                  n;
        logic [NumPorts-1:0] got;
        logic [NumPorts-1:0] prev;
        logic [NumPorts-1:0] rising;
        logic [NumPorts-1:0] expMask;
        applyReset();
        // port 2 preloads, so the pointer stays at port 0
        for (int p = 0; p < NumPorts; p++) begin
            doAccess(2, OpStore, SizeWord, addrT'(12'h300 + 4 * p), 32'h0F0F0000 + p, 0, r);
        end
        for (int round = 0; round < 2; round++) begin
            for (int p = 0; p < NumPorts; p++) begin
                reqData[p] = '{OpLoad, SizeWord, addrT'(12'h300 + 4 * p), '0};
                req[p] = 1'b1;
            end
            got = '0;
            prev = '0;
            order = 0;
            n = 0;
            while (got != '1 || ack != '0) begin
                @(negedge clk);
                n++;
                if (n > WaitLimit) stopRun("timeout in round-robin round");
                rising = ack & ~prev;
                prev = ack;
                if (rising != '0) begin
                    expMask = '0;
                    expMask[order] = 1'b1;
                    checkAck("ack rise order", rising, expMask);
                    order++;
                    for (int p = 0; p < NumPorts; p++) begin
                        if (rising[p]) begin
                            checkWord($sformatf("rspData[%0d]", p), rspData[p].rdata,
                                      expectLoad(SizeWord, addrT'(12'h300 + 4 * p)));
                            req[p] = 1'b0;
                            got[p] = 1'b1;
                        end
                    end
                end
            end
        end
    endtask

    task automatic runHeld(input int port, input memOpT op, input addrT addr, input wordT wdata);
        wordT                r;
        logic [NumPorts-1:0] mine;
        mine = '0;
        mine[port] = 1'b1;
        hold = 1'b1;
        reqData[port] = '{op, SizeWord, addr, wdata};
        req[port] = 1'b1;
        repeat (8) begin
            @(negedge clk);
            checkAck("ack under hold", ack, '0);
        end
        hold = 1'b0;
        @(negedge clk);
        // second pulse lands in the middle of the byte cycles
        hold = 1'b1;
        repeat (3) @(negedge clk);
        hold = 1'b0;
        waitAck(port);
        r = rspData[port].rdata;
        req[port] = 1'b0;
        @(negedge clk);
        checkAck("ack after req drop", ack & mine, '0);
        if (op == OpStore) begin
            updateModel(SizeWord, addr, wdata);
        end else begin
            checkWord("held load", r, expectLoad(SizeWord, addr));
        end
    endtask

    task automatic testHold();
        wordT r;
        runHeld(1, OpStore, 12'h400, 32'h5A6B7C8D);
        runHeld(2, OpLoad, 12'h400, '0);
        doAccess(0, OpLoad, SizeWord, 12'h400, '0, 0, r);
        checkWord("load after held store", r, 32'h5A6B7C8D);
    endtask

    task automatic testProtocol();
        wordT r;
        doAccess(1, OpStore, SizeWord, 12'h500, 32'hCAFEF00D, 6, r);
        doAccess(2, OpLoad, SizeWord, 12'h500, '0, 5, r);
        checkWord("load with long req", r, 32'hCAFEF00D);
        repeat (4) begin
            @(negedge clk);
            checkAck("ack after release", ack, '0);
        end
    endtask

    initial begin
        seed = 32'h58ac889c;
        errors = 0;
        hold = 1'b0;
        req = '0;
        for (int p = 0; p < NumPorts; p++) begin
            reqData[p] = '0;
        end
        for (int i = 0; i < RamDepth; i++) begin
            model[i] = '0;
        end
        applyReset();
        testWordLoad();
        testLanes();
        testRandom();
        testRoundRobin();
        testHold();
        testProtocol();
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
memPkg.sv
byteRam.sv
byteSequencer.sv
portArbiter.sv
memPortFront.sv
memSubsystem.sv
tbMemSubsystem.sv

// File: runSim.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tbMemSubsystem -f flist.f -o simMem
./obj_dir/simMem > sim.log 2>&1 || true
cat sim.log
if grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation ok"
else
    echo "simulation reported failure"
    exit 1
fi
